/* include/core_cfg.svh */
// Core configuration defines: widths, register count, memory depth, APB address map
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and instruction width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_IDX_W 5

// Instruction memory, one word per entry
`define IMEM_WORDS 64
`define IMEM_IDX_W 6

// APB address map, byte addresses
`define APB_ADDR_W 9
`define APB_IMEM_BASE 9'h000
`define APB_IMEM_END 9'h100
`define APB_CTRL_ADDR 9'h100
`define APB_RETIRED_ADDR 9'h104
`define APB_REG_BASE 9'h180

`endif

/* rtl/isa_pkg.sv */
// RV32I subset opcodes and funct3 codes, ALU operation and writeback source types
package isa_pkg;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU funct3, shared by OP_IMM and OP_REG
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Writeback source, no loads in this core
  typedef enum logic {
    WB_NONE,
    WB_ALU
  } wb_src_e;

endpackage

/* rtl/bus_pkg.sv */
// APB address region type and control register bit positions
package bus_pkg;

  // Decoded APB region
  typedef enum logic [1:0] {
    REGION_IMEM,
    REGION_CTRL,
    REGION_REGS,
    REGION_INVALID
  } apb_region_e;

  // Control register fields
  // Run is read/write
  localparam int CTRL_RUN_BIT = 0;
  // Halted is read only
  localparam int CTRL_HALT_BIT = 1;

endpackage

/* rtl/apb_host_port.sv */
// APB slave for program load, run control, status, retired count and register readback
`timescale 1ns/1ps
`include "core_cfg.svh"

module apb_host_port import bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`XLEN-1:0]       pwdata,
  output logic [`XLEN-1:0]       prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   halted,
  input  logic [`XLEN-1:0]       retired_count,
  input  logic [`XLEN-1:0]       host_reg_data,
  output logic                   imem_we,
  output logic [`IMEM_IDX_W-1:0] imem_addr,
  output logic [`XLEN-1:0]       imem_wdata,
  output logic                   run,
  output logic [`REG_IDX_W-1:0]  host_reg_idx
);

  apb_region_e region;
  logic        access;
  logic        ctrl_write;
  logic        halted_q;
  logic [`XLEN-1:0] status_word;

  // Address decode
  always_comb
  begin
    if (paddr >= `APB_REG_BASE)
      region = REGION_REGS;
    else if (paddr == `APB_CTRL_ADDR || paddr == `APB_RETIRED_ADDR)
      region = REGION_CTRL;
    else if (paddr < `APB_IMEM_END)
      region = REGION_IMEM;
    else
      region = REGION_INVALID;
  end

  // Access phase, zero wait states
  assign access     = psel && penable;
  assign pready     = 1'b1;
  assign ctrl_write = access && pwrite && (paddr == `APB_CTRL_ADDR);

  // Program load only while stopped
  assign imem_we    = access && pwrite && (region == REGION_IMEM) && !run;
  assign imem_addr  = paddr[`IMEM_IDX_W+1:2];
  assign imem_wdata = pwdata;

  // Register window, word indexed from APB_REG_BASE
  assign host_reg_idx = paddr[`REG_IDX_W+1:2];

  // Unmapped space, or program load during a run
  assign pslverr = access && ((region == REGION_INVALID) ||
                              (region == REGION_IMEM && pwrite && run));

  // Stale halted hidden once a new run starts
  always_comb
  begin
    status_word                = '0;
    status_word[CTRL_RUN_BIT]  = run;
    status_word[CTRL_HALT_BIT] = halted && !run;
  end

  // Read mux, imem is write only
  always_comb
  begin
    case (region)
      REGION_CTRL:
        prdata = (paddr == `APB_RETIRED_ADDR) ? retired_count : status_word;
      REGION_REGS:
        prdata = host_reg_data;
      default:
        prdata = '0;
    endcase
  end

  // Run bit set by host, dropped on halt rising edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      run      <= 1'b0;
      halted_q <= 1'b0;
    end
    else
    begin
      halted_q <= halted;
      if (ctrl_write)
        run <= pwdata[CTRL_RUN_BIT];
      else if (halted && !halted_q)
        run <= 1'b0;
    end
  end

  // APB protocol: access phase only inside a selected transfer
  a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
    else $error("penable high without psel");

endmodule

/* rtl/fetch_stage.sv */
// Fetch stage: program counter, instruction memory and fetch pipeline register
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_stage import isa_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic                   stall,
  input  logic                   redirect,
  input  logic [`XLEN-1:0]       redirect_pc,
  input  logic                   imem_we,
  input  logic [`IMEM_IDX_W-1:0] imem_addr,
  input  logic [`XLEN-1:0]       imem_wdata,
  output logic                   f_valid,
  output logic [`XLEN-1:0]       f_pc,
  output logic [`XLEN-1:0]       f_instr
);

  logic [`XLEN-1:0] imem [`IMEM_WORDS];
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] fetch_word;
  logic             run_q;
  logic             run_start;
  logic             done;
  logic             hold;
  logic             issue;

  // Host program load port
  always_ff @(posedge clk)
  begin
    if (imem_we)
      imem[imem_addr] <= imem_wdata;
  end

  // Word-aligned read at the PC
  assign fetch_word = imem[pc[`IMEM_IDX_W+1:2]];

  // New run restarts from PC 0
  assign run_start = run && !run_q;

  // Interlock keeps the current fetch register
  assign hold  = run && !run_start && !redirect && stall;
  // Issue unless stopped after ECALL
  assign issue = run && !run_start && !redirect && !stall && !done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      run_q   <= 1'b0;
      pc      <= '0;
      done    <= 1'b0;
      f_valid <= 1'b0;
    end
    else
    begin
      run_q <= run;
      // PC source
      if (run_start)
        pc <= '0;
      else if (run && redirect)
        pc <= redirect_pc;
      else if (issue)
        pc <= pc + `XLEN'd4;
      // ECALL stops issue, a redirect resumes it
      if (run_start || redirect)
        done <= 1'b0;
      else if (issue)
        done <= (fetch_word[6:0] == OP_SYSTEM);
      // Redirect drops the fetched item
      if (!hold)
        f_valid <= issue;
    end
  end

  // Fetch payload
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      f_pc    <= pc;
      f_instr <= fetch_word;
    end
  end

endmodule

/* rtl/decode_stage.sv */
// Decode stage: control unit, register file, hazard interlock and decode pipeline register
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage import isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  f_valid,
  input  logic [`XLEN-1:0]      f_pc,
  input  logic [`XLEN-1:0]      f_instr,
  input  logic                  redirect,
  input  logic                  e_valid,
  input  logic [`REG_IDX_W-1:0] e_rd,
  input  logic                  e_reg_write,
  input  logic                  wb_en,
  input  logic [`REG_IDX_W-1:0] wb_idx,
  input  logic [`XLEN-1:0]      wb_data,
  input  logic [`REG_IDX_W-1:0] host_reg_idx,
  output logic [`XLEN-1:0]      host_reg_data,
  output logic                  stall,
  output logic                  d_valid,
  output alu_op_e               d_alu_op,
  output logic [`XLEN-1:0]      d_op_a,
  output logic [`XLEN-1:0]      d_op_b,
  output logic [`REG_IDX_W-1:0] d_rd,
  output logic                  d_reg_write,
  output logic                  d_is_branch,
  output logic                  d_branch_ne,
  output logic [`XLEN-1:0]      d_branch_target,
  output logic                  d_is_halt
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [`REG_IDX_W-1:0] rs1;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`REG_IDX_W-1:0] rd;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  alu_op_e          alu_op;
  wb_src_e          wb_src;
  logic             op_b_imm;
  logic             uses_rs1;
  logic             uses_rs2;
  logic             is_branch;
  logic             is_halt;
  logic             rs1_hit;
  logic             rs2_hit;

  // Instruction fields
  assign opcode = f_instr[6:0];
  assign funct3 = f_instr[14:12];
  assign rd     = f_instr[11:7];
  assign rs1    = f_instr[19:15];
  assign rs2    = f_instr[24:20];

  // Immediates, sign extended
  assign imm_i = {{(`XLEN-12){f_instr[31]}}, f_instr[31:20]};
  assign imm_u = {f_instr[31:12], 12'b0};
  assign imm_b = {{(`XLEN-13){f_instr[31]}}, f_instr[31], f_instr[7],
                  f_instr[30:25], f_instr[11:8], 1'b0};

  // funct3 to ALU operation, sub from funct7 bit 5
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = sub ? ALU_SUB : ALU_ADD;
      F3_SLT:     op = ALU_SLT;
      F3_XOR:     op = ALU_XOR;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  // Control unit
  always_comb
  begin
    alu_op    = ALU_ADD;
    wb_src    = WB_NONE;
    imm       = imm_i;
    op_b_imm  = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    is_branch = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      OP_IMM:
      begin
        alu_op   = alu_from_funct(funct3, 1'b0);
        wb_src   = WB_ALU;
        op_b_imm = 1'b1;
        uses_rs1 = 1'b1;
      end
      OP_REG:
      begin
        alu_op   = alu_from_funct(funct3, f_instr[30]);
        wb_src   = WB_ALU;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_LUI:
      begin
        alu_op   = ALU_PASS_B;
        wb_src   = WB_ALU;
        imm      = imm_u;
        op_b_imm = 1'b1;
      end
      OP_BRANCH:
      begin
        // Operands compared in execute
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        is_branch = 1'b1;
      end
      OP_SYSTEM:
        is_halt = 1'b1;
      default:
      begin
        // Anything else retires as a no-op
      end
    endcase
  end

  // Register file write port, x0 never stored
  always_ff @(posedge clk)
  begin
    if (wb_en && wb_idx != '0)
      regs[wb_idx] <= wb_data;
  end

  // Reads see a same-cycle write
  assign rs1_data = (wb_en && wb_idx == rs1) ? wb_data : (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (wb_en && wb_idx == rs2) ? wb_data : (rs2 == '0) ? '0 : regs[rs2];

  // Host readback port
  assign host_reg_data = (host_reg_idx == '0) ? '0 : regs[host_reg_idx];

  // RAW hazard against execute (d_*) and result (e_*)
  assign rs1_hit = uses_rs1 && (rs1 != '0) &&
                   ((d_valid && d_reg_write && d_rd == rs1) ||
                    (e_valid && e_reg_write && e_rd == rs1));
  assign rs2_hit = uses_rs2 && (rs2 != '0) &&
                   ((d_valid && d_reg_write && d_rd == rs2) ||
                    (e_valid && e_reg_write && e_rd == rs2));
  assign stall = f_valid && (rs1_hit || rs2_hit);

  // Bubble on stall or redirect
  always_ff @(posedge clk)
  begin
    if (rst)
      d_valid <= 1'b0;
    else
      d_valid <= f_valid && !stall && !redirect;
  end

  // Decode payload
  always_ff @(posedge clk)
  begin
    d_alu_op        <= alu_op;
    d_op_a          <= rs1_data;
    d_op_b          <= op_b_imm ? imm : rs2_data;
    d_rd            <= rd;
    d_reg_write     <= (wb_src == WB_ALU);
    d_is_branch     <= is_branch;
    d_branch_ne     <= (funct3 == F3_BNE);
    d_branch_target <= f_pc + imm_b;
    d_is_halt       <= is_halt;
  end

  // Result stage must filter x0 writes
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_idx != '0)
    else $error("register file write to x0");

endmodule

/* rtl/execute_stage.sv */
// Execute stage: ALU, branch resolution and redirect, execute pipeline register
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_stage import isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  d_valid,
  input  alu_op_e               d_alu_op,
  input  logic [`XLEN-1:0]      d_op_a,
  input  logic [`XLEN-1:0]      d_op_b,
  input  logic [`REG_IDX_W-1:0] d_rd,
  input  logic                  d_reg_write,
  input  logic                  d_is_branch,
  input  logic                  d_branch_ne,
  input  logic [`XLEN-1:0]      d_branch_target,
  input  logic                  d_is_halt,
  output logic                  redirect,
  output logic [`XLEN-1:0]      redirect_pc,
  output logic                  e_valid,
  output logic [`XLEN-1:0]      e_result,
  output logic [`REG_IDX_W-1:0] e_rd,
  output logic                  e_reg_write,
  output logic                  e_is_halt
);

  logic [`XLEN-1:0] alu_out;
  logic             ops_equal;
  logic             taken;

  // ALU
  always_comb
  begin
    case (d_alu_op)
      ALU_ADD:    alu_out = d_op_a + d_op_b;
      ALU_SUB:    alu_out = d_op_a - d_op_b;
      ALU_AND:    alu_out = d_op_a & d_op_b;
      ALU_OR:     alu_out = d_op_a | d_op_b;
      ALU_XOR:    alu_out = d_op_a ^ d_op_b;
      ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(d_op_a) < $signed(d_op_b)};
      ALU_PASS_B: alu_out = d_op_b;
      default:    alu_out = '0;
    endcase
  end

  // BEQ on equal, BNE on not equal
  assign ops_equal = (d_op_a == d_op_b);
  assign taken     = d_is_branch && (ops_equal ^ d_branch_ne);

  // Redirect fetch, flush fetch and decode
  assign redirect    = d_valid && taken;
  assign redirect_pc = d_branch_target;

  always_ff @(posedge clk)
  begin
    if (rst)
      e_valid <= 1'b0;
    else
      e_valid <= d_valid;
  end

  // Result payload
  always_ff @(posedge clk)
  begin
    e_result    <= alu_out;
    e_rd        <= d_rd;
    e_reg_write <= d_reg_write;
    e_is_halt   <= d_is_halt;
  end

  // Decode drops its entry on redirect, so no back-to-back redirects
  a_redirect_single: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
    else $error("redirect held for more than one cycle");

endmodule

/* rtl/result_stage.sv */
// Result stage: register file write, retired instruction counter and halt detection
`timescale 1ns/1ps
`include "core_cfg.svh"

module result_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  run,
  input  logic                  e_valid,
  input  logic [`XLEN-1:0]      e_result,
  input  logic [`REG_IDX_W-1:0] e_rd,
  input  logic                  e_reg_write,
  input  logic                  e_is_halt,
  output logic                  wb_en,
  output logic [`REG_IDX_W-1:0] wb_idx,
  output logic [`XLEN-1:0]      wb_data,
  output logic                  halted,
  output logic [`XLEN-1:0]      retired_count
);

  logic run_q;
  logic run_start;

  // Host restart clears status
  assign run_start = run && !run_q;

  // Write enable, x0 filtered here
  always_ff @(posedge clk)
  begin
    if (rst)
      wb_en <= 1'b0;
    else
      wb_en <= e_valid && e_reg_write && (e_rd != '0);
  end

  always_ff @(posedge clk)
  begin
    wb_idx  <= e_rd;
    wb_data <= e_result;
  end

  // Halt on ECALL, count everything else
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      run_q         <= 1'b0;
      halted        <= 1'b0;
      retired_count <= '0;
    end
    else
    begin
      run_q <= run;
      if (run_start)
      begin
        halted        <= 1'b0;
        retired_count <= '0;
      end
      else if (e_valid)
      begin
        if (e_is_halt)
          halted <= 1'b1;
        else
          retired_count <= retired_count + 1'b1;
      end
    end
  end

endmodule

/* rtl/mini_core_top.sv */
// Core top level: APB host port and the fetch, decode, execute and result stages
`timescale 1ns/1ps
`include "core_cfg.svh"

module mini_core_top import isa_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`XLEN-1:0]       pwdata,
  output logic [`XLEN-1:0]       prdata,
  output logic                   pready,
  output logic                   pslverr
);

  // Host side
  logic                   imem_we;
  logic [`IMEM_IDX_W-1:0] imem_addr;
  logic [`XLEN-1:0]       imem_wdata;
  logic                   run;
  logic [`REG_IDX_W-1:0]  host_reg_idx;
  logic [`XLEN-1:0]       host_reg_data;
  logic                   halted;
  logic [`XLEN-1:0]       retired_count;

  // Fetch to decode
  logic                   f_valid;
  logic [`XLEN-1:0]       f_pc;
  logic [`XLEN-1:0]       f_instr;
  logic                   stall;

  // Decode to execute
  logic                   d_valid;
  alu_op_e                d_alu_op;
  logic [`XLEN-1:0]       d_op_a;
  logic [`XLEN-1:0]       d_op_b;
  logic [`REG_IDX_W-1:0]  d_rd;
  logic                   d_reg_write;
  logic                   d_is_branch;
  logic                   d_branch_ne;
  logic [`XLEN-1:0]       d_branch_target;
  logic                   d_is_halt;

  // Execute to result, and branch redirect
  logic                   e_valid;
  logic [`XLEN-1:0]       e_result;
  logic [`REG_IDX_W-1:0]  e_rd;
  logic                   e_reg_write;
  logic                   e_is_halt;
  logic                   redirect;
  logic [`XLEN-1:0]       redirect_pc;

  // Register file write back
  logic                   wb_en;
  logic [`REG_IDX_W-1:0]  wb_idx;
  logic [`XLEN-1:0]       wb_data;

  // Port names match the wires above
  apb_host_port u_apb_host_port (.*);

  fetch_stage u_fetch_stage (.*);

  decode_stage u_decode_stage (.*);

  execute_stage u_execute_stage (.*);

  result_stage u_result_stage (.*);

endmodule

/* verif/tb_mini_core.sv */
// Core testbench with APB program load, run control, halt polling and table-driven checks
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_mini_core import bus_pkg::*; ();

  localparam int MAX_ROWS  = 80;
  // Row operations
  localparam int ROW_WRITE = 0;
  localparam int ROW_READ  = 1;
  localparam int ROW_WAIT  = 2;

  logic                   clk;
  logic                   rst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`XLEN-1:0]       pwdata;
  logic [`XLEN-1:0]       prdata;
  logic                   pready;
  logic                   pslverr;

  // Stimulus and expected values
  int                     row_op   [MAX_ROWS];
  logic [`APB_ADDR_W-1:0] row_addr [MAX_ROWS];
  logic [`XLEN-1:0]       row_data [MAX_ROWS];
  logic                   row_err  [MAX_ROWS];
  int                     n_rows;
  int                     prog_idx;

  int errors;
  int checks;
  int cycles;
  int cycle_limit;

  mini_core_top u_mini_core_top (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Run length guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("Timed out after %0d cycles without finishing the table", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // RV32I encodings
  function automatic logic [31:0] imm_instr(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // Byte offset with bit 0 dropped
  function automatic logic [31:0] branch_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic add_row(input int op, input logic [`APB_ADDR_W-1:0] addr,
                         input logic [`XLEN-1:0] data, input logic err);
    row_op[n_rows]   = op;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_err[n_rows]  = err;
    n_rows++;
  endtask

  // Next program word
  task automatic add_instr(input logic [31:0] word);
    add_row(ROW_WRITE, 9'(`APB_IMEM_BASE + 4 * prog_idx), word, 1'b0);
    prog_idx++;
  endtask

  task automatic expect_reg(input int idx, input logic [`XLEN-1:0] value);
    add_row(ROW_READ, 9'(`APB_REG_BASE + 4 * idx), value, 1'b0);
  endtask

  task automatic build_table();
    logic [11:0] a;
    logic [11:0] b;
    logic [31:0] x1;
    logic [31:0] x2;
    a  = 12'($urandom());
    b  = 12'($urandom());
    // ADDI sign extends
    x1 = {{20{a[11]}}, a};
    x2 = {{20{b[11]}}, b};
    n_rows   = 0;
    // First program with ALU ops, x0 writes and branches
    prog_idx = 0;
    add_instr(imm_instr(3'b000, 5'd10, 5'd0, 12'd85));
    add_instr(imm_instr(3'b000, 5'd1, 5'd0, a));
    add_instr(imm_instr(3'b000, 5'd2, 5'd0, b));
    // Dependent on the two ADDIs just before
    add_instr(reg_instr(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    add_instr(reg_instr(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
    add_instr(reg_instr(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2));
    add_instr(reg_instr(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2));
    add_instr(reg_instr(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2));
    add_instr(reg_instr(7'b0000000, 3'b010, 5'd8, 5'd1, 5'd2));
    add_instr(lui_instr(5'd9, 20'habcde));
    add_instr(imm_instr(3'b000, 5'd0, 5'd0, 12'd5));
    add_instr(reg_instr(7'b0000000, 3'b000, 5'd0, 5'd9, 5'd9));
    // Taken BEQ to 60 skips the next two
    add_instr(branch_instr(3'b000, 5'd1, 5'd1, 13'd12));
    add_instr(imm_instr(3'b000, 5'd10, 5'd0, 12'd1));
    add_instr(imm_instr(3'b000, 5'd10, 5'd0, 12'd2));
    // BNE not taken
    add_instr(branch_instr(3'b001, 5'd1, 5'd1, 13'd8));
    add_instr(imm_instr(3'b000, 5'd11, 5'd0, 12'd7));
    // BNE taken to 76
    add_instr(branch_instr(3'b001, 5'd9, 5'd0, 13'd8));
    add_instr(imm_instr(3'b000, 5'd11, 5'd0, 12'd9));
    add_instr(imm_instr(3'b000, 5'd12, 5'd11, 12'hffd));
    add_instr(32'h0000_0073);
    add_row(ROW_WRITE, `APB_CTRL_ADDR, 32'(1 << CTRL_RUN_BIT), 1'b0);
    add_row(ROW_WAIT, `APB_CTRL_ADDR, '0, 1'b0);
    add_row(ROW_READ, `APB_CTRL_ADDR, 32'(1 << CTRL_HALT_BIT), 1'b0);
    // 13 up to the BEQ plus 60, 64, 68 and 76
    add_row(ROW_READ, `APB_RETIRED_ADDR, 32'd17, 1'b0);
    expect_reg(0, 32'd0);
    expect_reg(1, x1);
    expect_reg(2, x2);
    expect_reg(3, x1 + x2);
    expect_reg(4, x1 - x2);
    expect_reg(5, x1 & x2);
    expect_reg(6, x1 | x2);
    expect_reg(7, x1 ^ x2);
    expect_reg(8, ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0);
    expect_reg(9, 32'habcde000);
    expect_reg(10, 32'd85);
    expect_reg(11, 32'd7);
    expect_reg(12, 32'd4);
    // Unmapped hole between control and register window
    add_row(ROW_WRITE, 9'h108, 32'h1234_5678, 1'b1);
    add_row(ROW_READ, 9'h140, 32'd0, 1'b1);
    // Self loop keeps the core running
    prog_idx = 0;
    add_instr(branch_instr(3'b000, 5'd0, 5'd0, 13'd0));
    add_row(ROW_WRITE, `APB_CTRL_ADDR, 32'(1 << CTRL_RUN_BIT), 1'b0);
    add_row(ROW_WRITE, 9'h020, 32'h0000_0073, 1'b1);
    // Host stop leaves halted clear
    add_row(ROW_WRITE, `APB_CTRL_ADDR, 32'd0, 1'b0);
    add_row(ROW_READ, `APB_CTRL_ADDR, 32'd0, 1'b0);
    // Second program is a dependent chain
    prog_idx = 0;
    add_instr(imm_instr(3'b000, 5'd1, 5'd0, 12'd100));
    add_instr(imm_instr(3'b000, 5'd2, 5'd1, 12'hfe2));
    add_instr(reg_instr(7'b0000000, 3'b100, 5'd3, 5'd2, 5'd1));
    add_instr(32'h0000_0073);
    add_row(ROW_WRITE, `APB_CTRL_ADDR, 32'(1 << CTRL_RUN_BIT), 1'b0);
    add_row(ROW_WAIT, `APB_CTRL_ADDR, '0, 1'b0);
    add_row(ROW_READ, `APB_RETIRED_ADDR, 32'd3, 1'b0);
    expect_reg(1, 32'd100);
    expect_reg(2, 32'd70);
    expect_reg(3, 32'd34);
    // Untouched by the second program
    expect_reg(12, 32'd4);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Error at %0t ns: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
    end
  endtask

  // Setup and access phases
  task automatic write_word(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic read_word(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    // Mid access phase
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value({31'b0, pready}, 32'd1, "pready in access phase");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_for_halt();
    logic [31:0] status;
    logic        err;
    status = '0;
    while (!status[CTRL_HALT_BIT])
    begin
      read_word(`APB_CTRL_ADDR, status, err);
      check_value({31'b0, err}, 32'd0, "pslverr on status poll");
    end
  endtask

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    clk         = 1'b0;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    cycle_limit = 0;
    void'($urandom(32'hd712));
    build_table();
    cycle_limit = 40 * n_rows;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_rows; i++)
    begin
      case (row_op[i])
        ROW_WRITE:
        begin
          write_word(row_addr[i], row_data[i], err);
          check_value({31'b0, err}, {31'b0, row_err[i]},
                      $sformatf("pslverr on write to 0x%h", row_addr[i]));
        end
        ROW_READ:
        begin
          read_word(row_addr[i], rdata, err);
          check_value(rdata, row_data[i], $sformatf("read data at 0x%h", row_addr[i]));
          check_value({31'b0, err}, {31'b0, row_err[i]},
                      $sformatf("pslverr on read at 0x%h", row_addr[i]));
        end
        default:
          wait_for_halt();
      endcase
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/apb_host_port.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/mini_core_top.sv
verif/tb_mini_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_mini_core -o tb_mini_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_mini_core)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
